/* source/fetch_pkg.sv */
package fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Base types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] addr_t; // Byte address.
	typedef logic [31:0] inst_t; // One RV32 instruction.
	typedef logic [1:0]  burst_t;
	typedef logic [3:0]  len_t;  // Beats minus one.

	localparam burst_t BURST_FIXED = 2'd0;
	localparam burst_t BURST_INCR  = 2'd1;

	// Cache line geometry.
	localparam int   LINE_WORDS = 4;
	localparam int   LINE_BYTES = 16;
	localparam len_t BURST_LEN  = 4'd3; // Full line refill.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and decoder structs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		addr_t  addr;
		burst_t burst;
		len_t   len;
	} ar_req_t;

	typedef struct packed {
		inst_t data;
		logic  last; // Final beat of the burst.
	} r_beat_t;

	// What the decoder sees.
	typedef struct packed {
		addr_t pc;
		inst_t inst;
	} fetch_out_t;

endpackage

/* source/icache.sv */
`timescale 1ns/1ps

module icache #(
	parameter int ICACHE_SETS = 16
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             lookup,
	input  fetch_pkg::addr_t pc,
	output logic             hit_valid,
	output logic             hit,
	output fetch_pkg::inst_t hit_data,
	input  logic             fill_valid,
	input  fetch_pkg::addr_t fill_addr,
	input  fetch_pkg::inst_t fill_data
);
	import fetch_pkg::*;

	localparam int OFF_W  = $clog2(LINE_BYTES);
	localparam int WORD_W = $clog2(LINE_WORDS);
	localparam int IDX_W  = $clog2(ICACHE_SETS);
	localparam int TAG_W  = $bits(addr_t) - IDX_W - OFF_W;

	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [IDX_W-1:0]  idx_t;
	typedef logic [WORD_W-1:0] word_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	tag_t                  tag_mem    [ICACHE_SETS];
	inst_t                 data_mem   [ICACHE_SETS][LINE_WORDS];
	logic [LINE_WORDS-1:0] word_valid [ICACHE_SETS]; // One bit per word.

	tag_t  look_tag;
	idx_t  look_idx;
	word_t look_word;
	tag_t  fill_tag;
	idx_t  fill_idx;
	word_t fill_word;

	// Address split for both ports.
	assign look_tag  = pc[$bits(addr_t)-1 -: TAG_W];
	assign look_idx  = pc[OFF_W +: IDX_W];
	assign look_word = pc[OFF_W-1 -: WORD_W];
	assign fill_tag  = fill_addr[$bits(addr_t)-1 -: TAG_W];
	assign fill_idx  = fill_addr[OFF_W +: IDX_W];
	assign fill_word = fill_addr[OFF_W-1 -: WORD_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Refill port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[fill_idx][fill_word] <= fill_data;
			if (fill_word == '0)
				tag_mem[fill_idx] <= fill_tag; // New line owner.
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			word_valid <= '{default: '0};
		end else if (fill_valid) begin
			// First word starts the line over.
			if (fill_word == '0)
				word_valid[fill_idx] <= LINE_WORDS'(1);
			else
				word_valid[fill_idx][fill_word] <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup, answered one cycle later.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (!rst_n)
			hit_valid <= 1'b0;
		else
			hit_valid <= lookup;
	end

	always_ff @(posedge clock) begin
		if (lookup) begin
			// Partly filled lines never hit.
			hit      <= (tag_mem[look_idx] == look_tag) && (&word_valid[look_idx]);
			hit_data <= data_mem[look_idx][look_word];
		end
	end

	// The fetch unit never looks up while a refill is running.
	no_lookup_during_fill_a: assert property (@(posedge clock) disable iff (!rst_n)
		!(lookup && fill_valid));

endmodule

/* source/ifu.sv */
`timescale 1ns/1ps

module ifu #(
	parameter fetch_pkg::addr_t RESET_PC    = 32'h3000_0000,
	parameter fetch_pkg::addr_t CACHE_BASE  = 32'ha000_0000,
	parameter fetch_pkg::addr_t CACHE_LIMIT = 32'ha200_0000
) (
	input  logic                  clock,
	input  logic                  rst_n,
	output logic                  ar_valid,
	input  logic                  ar_ready,
	output fetch_pkg::ar_req_t    ar_req,
	input  logic                  r_valid,
	input  fetch_pkg::r_beat_t    r_beat,
	input  logic                  jump_wrong,
	input  fetch_pkg::addr_t      jump_addr,
	output logic                  idu_valid,
	input  logic                  idu_ready,
	output fetch_pkg::fetch_out_t fetch,
	output logic                  lookup,
	output fetch_pkg::addr_t      pc,
	input  logic                  hit_valid,
	input  logic                  hit,
	input  fetch_pkg::inst_t      hit_data,
	output logic                  fill_valid,
	output fetch_pkg::addr_t      fill_addr,
	output fetch_pkg::inst_t      fill_data
);
	import fetch_pkg::*;

	localparam int    OFF_W     = $clog2(LINE_BYTES);
	localparam addr_t LINE_MASK = ~addr_t'(LINE_BYTES - 1);

	typedef enum logic [2:0] {
		S_IDLE,    // Fetch starts here.
		S_LOOKUP,  // Cache answer due.
		S_REQUEST, // Address on the bus.
		S_RECEIVE, // Waiting for beats.
		S_DELIVER  // Instruction offered to the decoder.
	} state_t;

	state_t state;
	state_t state_next;
	logic   cached;
	logic   xfer_done;
	logic   beat_match;
	logic   jump_pend;
	addr_t  jump_target;
	addr_t  pc_next;
	inst_t  inst_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Region decode and transfer status.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign cached     = (pc >= CACHE_BASE) && (pc < CACHE_LIMIT);
	assign xfer_done  = (state == S_RECEIVE) && r_valid && r_beat.last;
	assign beat_match = !cached || (fill_addr[OFF_W-1:2] == pc[OFF_W-1:2]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (jump_wrong)
					state_next = S_IDLE; // Restart at the new pc.
				else if (cached)
					state_next = S_LOOKUP;
				else
					state_next = S_REQUEST;
			end
			S_LOOKUP: begin
				if (jump_wrong)
					state_next = S_IDLE;
				else if (hit_valid)
					state_next = hit ? S_DELIVER : S_REQUEST;
			end
			S_REQUEST: begin
				if (ar_ready)
					state_next = S_RECEIVE;
			end
			S_RECEIVE: begin
				// Pending redirect throws the result away.
				if (xfer_done)
					state_next = (jump_wrong || jump_pend) ? S_IDLE : S_DELIVER;
			end
			S_DELIVER: begin
				if (jump_wrong || idu_ready)
					state_next = S_IDLE;
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_comb begin
		pc_next = pc;
		if (xfer_done && (jump_wrong || jump_pend))
			pc_next = jump_wrong ? jump_addr : jump_target;
		else if (jump_wrong && (state inside {S_IDLE, S_LOOKUP, S_DELIVER}))
			pc_next = jump_addr;
		else if ((state == S_DELIVER) && idu_ready)
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= S_IDLE;
			pc    <= RESET_PC;
		end else begin
			state <= state_next;
			pc    <= pc_next;
		end
	end

	// Redirects during a bus transfer wait for its last beat.
	always_ff @(posedge clock) begin
		if (!rst_n)
			jump_pend <= 1'b0;
		else if (xfer_done)
			jump_pend <= 1'b0;
		else if (jump_wrong && (state inside {S_REQUEST, S_RECEIVE}))
			jump_pend <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (jump_wrong)
			jump_target <= jump_addr; // Latest redirect wins.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Refill sequencing and instruction capture.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if ((state == S_LOOKUP) && hit_valid && !hit)
			fill_addr <= pc & LINE_MASK; // Burst starts at the line base.
		else if (fill_valid)
			fill_addr <= fill_addr + 32'd4;
	end

	always_ff @(posedge clock) begin
		if ((state == S_LOOKUP) && hit_valid && hit)
			inst_q <= hit_data;
		else if ((state == S_RECEIVE) && r_valid && beat_match)
			inst_q <= r_beat.data;
	end

	assign fill_valid = (state == S_RECEIVE) && r_valid && cached;
	assign fill_data  = r_beat.data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lookup       = (state == S_IDLE) && cached && !jump_wrong;
	assign ar_valid     = (state == S_REQUEST);
	assign ar_req.addr  = cached ? (pc & LINE_MASK) : pc;
	assign ar_req.burst = cached ? BURST_INCR : BURST_FIXED;
	assign ar_req.len   = cached ? BURST_LEN : len_t'(0); // Boot reads are single beats.

	assign idu_valid  = (state == S_DELIVER);
	assign fetch.pc   = pc;
	assign fetch.inst = inst_q;

	ar_stable_a: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_req));

	// Decoder sees the same word until it takes it.
	fetch_hold_a: assert property (@(posedge clock) disable iff (!rst_n)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(fetch));

	no_beat_in_idle_a: assert property (@(posedge clock) disable iff (!rst_n)
		(state == S_IDLE) |-> !r_valid);

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC    = 32'h3000_0000,
	parameter fetch_pkg::addr_t CACHE_BASE  = 32'ha000_0000,
	parameter fetch_pkg::addr_t CACHE_LIMIT = 32'ha200_0000,
	parameter int               ICACHE_SETS = 16
) (
	input  logic                  clock,
	input  logic                  rst_n,
	output logic                  ar_valid,
	input  logic                  ar_ready,
	output fetch_pkg::ar_req_t    ar_req,
	input  logic                  r_valid,
	input  fetch_pkg::r_beat_t    r_beat,
	input  logic                  jump_wrong,
	input  fetch_pkg::addr_t      jump_addr,
	output logic                  idu_valid,
	input  logic                  idu_ready,
	output fetch_pkg::fetch_out_t fetch
);
	import fetch_pkg::*;

	// Fetch unit to cache.
	logic  lookup;
	addr_t pc;
	logic  hit_valid;
	logic  hit;
	inst_t hit_data;
	logic  fill_valid;
	addr_t fill_addr;
	inst_t fill_data;

	ifu #(
		.RESET_PC    (RESET_PC),
		.CACHE_BASE  (CACHE_BASE),
		.CACHE_LIMIT (CACHE_LIMIT)
	) i_ifu (
		.clock      (clock),
		.rst_n      (rst_n),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar_req     (ar_req),
		.r_valid    (r_valid),
		.r_beat     (r_beat),
		.jump_wrong (jump_wrong),
		.jump_addr  (jump_addr),
		.idu_valid  (idu_valid),
		.idu_ready  (idu_ready),
		.fetch      (fetch),
		.lookup     (lookup),
		.pc         (pc),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data),
		.fill_valid (fill_valid),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data)
	);

	icache #(
		.ICACHE_SETS (ICACHE_SETS)
	) i_icache (
		.clock      (clock),
		.rst_n      (rst_n),
		.lookup     (lookup),
		.pc         (pc),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.hit_data   (hit_data),
		.fill_valid (fill_valid),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data)
	);

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               ar_valid,
	output logic               ar_ready,
	input  fetch_pkg::ar_req_t ar_req,
	output logic               r_valid,
	output fetch_pkg::r_beat_t r_beat
);
	import fetch_pkg::*;

	int      req_count; // Accepted requests.
	ar_req_t last_req;

	// Word contents follow from the byte address.
	function automatic inst_t word_at(input addr_t addr);
		return addr ^ 32'h5a5a_5a5a;
	endfunction

	initial begin
		ar_req_t req;
		addr_t   addr;
		int      beat;
		ar_ready  = 1'b0;
		r_valid   = 1'b0;
		r_beat    = '0;
		req_count = 0;
		last_req  = '0;
		forever begin
			@(negedge clock);
			if (rst_n && ar_valid) begin
				repeat ($urandom_range(3, 0)) @(negedge clock);
				req      = ar_req; // Held stable while ar_valid is high.
				ar_ready = 1'b1;
				@(posedge clock);
				req_count++;
				last_req = req;
				@(negedge clock);
				ar_ready = 1'b0;
				addr     = req.addr;
				for (beat = 0; beat <= int'(req.len); beat++) begin
					repeat ($urandom_range(3, 0)) @(negedge clock);
					r_valid     = 1'b1;
					r_beat.data = word_at(addr);
					r_beat.last = (beat == int'(req.len));
					@(negedge clock);
					r_valid = 1'b0;
					if (req.burst == BURST_INCR)
						addr = addr + 32'd4;
				end
			end
		end
	end

endmodule

/* verif/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
	import fetch_pkg::*;

	localparam int    CLK_PERIOD  = 4;
	localparam addr_t RESET_PC    = 32'h3000_0000;
	localparam int    WAIT_CYCLES = 100; // Longest wait for one fetch.
	localparam int    WATCHDOG_NS = 50 * WAIT_CYCLES * CLK_PERIOD; // Room for 50 fetch waits.

	logic       clock;
	logic       rst_n;
	logic       ar_valid;
	logic       ar_ready;
	ar_req_t    ar_req;
	logic       r_valid;
	r_beat_t    r_beat;
	logic       jump_wrong;
	addr_t      jump_addr;
	logic       idu_valid;
	logic       idu_ready;
	fetch_out_t fetch;

	fetch_top #(
		.RESET_PC    (RESET_PC),
		.CACHE_BASE  (32'ha000_0000),
		.CACHE_LIMIT (32'ha200_0000),
		.ICACHE_SETS (16)
	) i_fetch_top (
		.clock      (clock),
		.rst_n      (rst_n),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar_req     (ar_req),
		.r_valid    (r_valid),
		.r_beat     (r_beat),
		.jump_wrong (jump_wrong),
		.jump_addr  (jump_addr),
		.idu_valid  (idu_valid),
		.idu_ready  (idu_ready),
		.fetch      (fetch)
	);

	mem_model i_mem_model (
		.clock    (clock),
		.rst_n    (rst_n),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.ar_req   (ar_req),
		.r_valid  (r_valid),
		.r_beat   (r_beat)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic inst_t expected_inst(input addr_t addr);
		return addr ^ 32'h5a5a_5a5a; // Memory image rule.
	endfunction

	task automatic report_error(input string msg);
		$display("ERR at %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first mismatch.");
	endtask

	task automatic give_up(input string what);
		$display("Gave up after %0d cycles waiting for %s.", WAIT_CYCLES, what);
		$display("Some tests failed");
		$fatal(1, "Wait timeout.");
	endtask

	// Wait for a delivered instruction, then check it and the request count.
	task automatic wait_fetch(input addr_t exp_pc, input int exp_count);
		int cycles;
		cycles = 0;
		while (!idu_valid) begin
			if (cycles == WAIT_CYCLES) begin
				give_up("an instruction");
			end else begin
				@(negedge clock);
				cycles++;
			end
		end
		assert (fetch.pc == exp_pc)
			else report_error($sformatf("pc %h, expected %h", fetch.pc, exp_pc));
		assert (fetch.inst == expected_inst(exp_pc))
			else report_error($sformatf("inst %h at pc %h", fetch.inst, exp_pc));
		assert (i_mem_model.req_count == exp_count)
			else report_error($sformatf("%0d requests, expected %0d",
				i_mem_model.req_count, exp_count));
	endtask

	task automatic wait_request();
		int cycles;
		cycles = 0;
		while (!ar_valid) begin
			if (cycles == WAIT_CYCLES) begin
				give_up("a bus request");
			end else begin
				@(negedge clock);
				cycles++;
			end
		end
	endtask

	task automatic accept_fetch();
		idu_ready = 1'b1;
		@(negedge clock);
		idu_ready = 1'b0;
	endtask

	task automatic redirect(input addr_t target);
		jump_wrong = 1'b1;
		jump_addr  = target;
		@(negedge clock);
		jump_wrong = 1'b0;
	endtask

	// Line refills are 4-beat incrementing bursts and boot reads single fixed beats.
	task automatic check_last_req(input addr_t addr, input logic line_fill);
		ar_req_t req;
		req = i_mem_model.last_req;
		assert (req.addr == addr)
			else report_error($sformatf("request at %h, expected %h", req.addr, addr));
		assert (req.burst == (line_fill ? 2'd1 : 2'd0))
			else report_error($sformatf("burst type %0d at %h", req.burst, addr));
		assert (req.len == (line_fill ? 4'd3 : 4'd0))
			else report_error($sformatf("burst length %0d at %h", req.len, addr));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_boot_fetch();
		int i;
		for (i = 0; i < 8; i++) begin
			wait_fetch(RESET_PC + 32'(4 * i), i + 1); // One read per word.
			check_last_req(RESET_PC + 32'(4 * i), 1'b0);
			accept_fetch();
		end
	endtask

	task automatic test_miss_refill();
		int base;
		base = i_mem_model.req_count;
		redirect(32'ha000_0104);
		wait_fetch(32'ha000_0104, base + 1);
		check_last_req(32'ha000_0100, 1'b1);
		accept_fetch();
	endtask

	task automatic test_hits();
		int base;
		base = i_mem_model.req_count;
		wait_fetch(32'ha000_0108, base);
		accept_fetch();
		wait_fetch(32'ha000_010c, base);
		accept_fetch();
		redirect(32'ha000_0100);
		wait_fetch(32'ha000_0100, base);
		accept_fetch();
		redirect(32'ha000_0110); // Next line misses.
		wait_fetch(32'ha000_0110, base + 1);
		check_last_req(32'ha000_0110, 1'b1);
		accept_fetch();
	endtask

	task automatic test_back_pressure();
		int         base;
		int         hold;
		fetch_out_t held;
		base = i_mem_model.req_count;
		hold = $urandom_range(15, 5);
		wait_fetch(32'ha000_0114, base);
		held = fetch;
		repeat (hold) begin
			@(negedge clock);
			assert (idu_valid && (fetch == held))
				else report_error("fetch output moved while the decoder stalled");
			assert (i_mem_model.req_count == base)
				else report_error("bus request issued while the decoder stalled");
		end
		accept_fetch();
		wait_fetch(32'ha000_0118, base);
		accept_fetch();
	endtask

	task automatic test_redirect_in_miss();
		int base;
		base = i_mem_model.req_count;
		redirect(32'ha000_0300);
		wait_request();
		redirect(32'ha000_0118); // Burst to 0x300 still in flight.
		wait_fetch(32'ha000_0118, base + 1);
		check_last_req(32'ha000_0300, 1'b1);
		accept_fetch();
		redirect(32'ha000_0300);
		wait_fetch(32'ha000_0300, base + 1);
		accept_fetch();
	endtask

	initial begin
		void'($urandom(97));
		clock      = 1'b0;
		rst_n      = 1'b0;
		jump_wrong = 1'b0;
		jump_addr  = '0;
		idu_ready  = 1'b0;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		test_boot_fetch();
		test_miss_refill();
		test_hits();
		test_back_pressure();
		test_redirect_in_miss();
		$display("All tests passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished.", WATCHDOG_NS);
		$display("Some tests failed");
		$fatal(1, "Watchdog timeout.");
	end

endmodule

/* files.f */
source/fetch_pkg.sv
source/icache.sv
source/ifu.sv
source/fetch_top.sv
verif/mem_model.sv
verif/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front

sources:
  - source/fetch_pkg.sv
  - source/icache.sv
  - source/ifu.sv
  - source/fetch_top.sv
  - target: simulation
    files:
      - verif/mem_model.sv
      - verif/tb_fetch_top.sv
